// File: source/mcu_ctrl_pkg.sv
/*
 * MCU always-on control package
 * shared widths, interrupt positions, power command and control types
 */
package mcu_ctrl_pkg;

  localparam int unsigned NUM_PWR_DOMAINS = 4;
  localparam int unsigned NUM_FAST_IRQ    = 16;
  localparam int unsigned IRQ_WIDTH       = 32;

  // core interrupt vector positions
  localparam int unsigned IRQ_SW_BIT    = 3;
  localparam int unsigned IRQ_TIMER_BIT = 7;
  localparam int unsigned IRQ_EXT_BIT   = 11;
  localparam int unsigned IRQ_FAST_LSB  = 16;

  typedef logic [$clog2(NUM_PWR_DOMAINS)-1:0] pwr_dom_idx_t;
  typedef logic [NUM_FAST_IRQ-1:0]            fast_irq_t;
  typedef logic [IRQ_WIDTH-1:0]               irq_vec_t;
  typedef logic [NUM_PWR_DOMAINS-1:0]         pwr_ack_n_t;

  // power map: cpu, peripheral, memory bank 0, memory bank 1
  localparam pwr_dom_idx_t PWR_DOM_CPU = 2'd0;

  typedef struct packed {
    pwr_dom_idx_t dom;
    logic         power_on;
  } pwr_cmd_t;

  // all bits active low, low means the gating action is applied
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic clkgate_en_n;
  } pwr_ctrl_t;

  typedef enum logic [3:0] {
    PWR_ON,
    PWR_ISO,
    PWR_RST,
    PWR_GATE,
    PWR_SW_OFF,
    PWR_OFF,
    PWR_SW_ON,
    PWR_UNGATE,
    PWR_UNRST,
    PWR_UNISO
  } pwr_state_e;

endpackage

// File: source/power_domain_fsm.sv
/*
 * Power domain sequencer
 * steps one domain through isolation, reset, clock gate and switch
 */
`timescale 1ns/1ps

module power_domain_fsm (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    start_i,
  input  logic                    power_on_i,
  input  logic                    pwr_ack_ni,
  output mcu_ctrl_pkg::pwr_ctrl_t pwr_ctrl_o,
  output logic                    idle_o
);

  mcu_ctrl_pkg::pwr_state_e state_q;
  mcu_ctrl_pkg::pwr_state_e state_d;
  mcu_ctrl_pkg::pwr_ctrl_t  ctrl_q;
  mcu_ctrl_pkg::pwr_ctrl_t  ctrl_d;
  logic                     ack_q;

  // next state, one step per cycle except the switch waits
  always_comb begin
    state_d = state_q;
    case (state_q)
      mcu_ctrl_pkg::PWR_ON: begin
        if (start_i && !power_on_i) begin
          state_d = mcu_ctrl_pkg::PWR_ISO;
        end
      end
      mcu_ctrl_pkg::PWR_ISO:    state_d = mcu_ctrl_pkg::PWR_RST;
      mcu_ctrl_pkg::PWR_RST:    state_d = mcu_ctrl_pkg::PWR_GATE;
      mcu_ctrl_pkg::PWR_GATE:   state_d = mcu_ctrl_pkg::PWR_SW_OFF;
      mcu_ctrl_pkg::PWR_SW_OFF: begin
        if (!ack_q) begin
          state_d = mcu_ctrl_pkg::PWR_OFF;
        end
      end
      mcu_ctrl_pkg::PWR_OFF: begin
        if (start_i && power_on_i) begin
          state_d = mcu_ctrl_pkg::PWR_SW_ON;
        end
      end
      mcu_ctrl_pkg::PWR_SW_ON: begin
        if (ack_q) begin
          state_d = mcu_ctrl_pkg::PWR_UNGATE;
        end
      end
      mcu_ctrl_pkg::PWR_UNGATE: state_d = mcu_ctrl_pkg::PWR_UNRST;
      mcu_ctrl_pkg::PWR_UNRST:  state_d = mcu_ctrl_pkg::PWR_UNISO;
      mcu_ctrl_pkg::PWR_UNISO:  state_d = mcu_ctrl_pkg::PWR_ON;
      default:                  state_d = mcu_ctrl_pkg::PWR_ON;
    endcase
  end

  // control bits that belong to the next state
  always_comb begin
    ctrl_d = '1;
    case (state_d)
      mcu_ctrl_pkg::PWR_ISO: begin
        ctrl_d.isogate_en_n = 1'b0;
      end
      mcu_ctrl_pkg::PWR_RST: begin
        ctrl_d.isogate_en_n = 1'b0;
        ctrl_d.rst_n        = 1'b0;
      end
      mcu_ctrl_pkg::PWR_GATE: begin
        ctrl_d.isogate_en_n = 1'b0;
        ctrl_d.rst_n        = 1'b0;
        ctrl_d.clkgate_en_n = 1'b0;
      end
      mcu_ctrl_pkg::PWR_SW_OFF, mcu_ctrl_pkg::PWR_OFF: begin
        ctrl_d = '0;
      end
      mcu_ctrl_pkg::PWR_SW_ON: begin
        ctrl_d              = '0;
        ctrl_d.pwrgate_en_n = 1'b1;
      end
      mcu_ctrl_pkg::PWR_UNGATE: begin
        ctrl_d.isogate_en_n = 1'b0;
        ctrl_d.rst_n        = 1'b0;
      end
      mcu_ctrl_pkg::PWR_UNRST: begin
        ctrl_d.isogate_en_n = 1'b0;
      end
      default: begin
        ctrl_d = '1;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= mcu_ctrl_pkg::PWR_ON;
      ctrl_q  <= '1;
      // switch is closed out of reset
      ack_q   <= 1'b1;
    end else begin
      state_q <= state_d;
      ctrl_q  <= ctrl_d;
      ack_q   <= pwr_ack_ni;
    end
  end

  assign pwr_ctrl_o = ctrl_q;
  assign idle_o     = (state_q == mcu_ctrl_pkg::PWR_ON) ||
                      (state_q == mcu_ctrl_pkg::PWR_OFF);

endmodule

// File: source/power_manager.sv
/*
 * Power manager
 * accepts on/off commands and starts the addressed domain sequencer
 */
`timescale 1ns/1ps

module power_manager (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  input  logic                                                   cmd_valid_i,
  input  mcu_ctrl_pkg::pwr_cmd_t                                 cmd_i,
  input  logic                                                   core_sleep_i,
  input  mcu_ctrl_pkg::pwr_ack_n_t                               pwr_ack_ni,
  output logic                                                   cmd_ready_o,
  output mcu_ctrl_pkg::pwr_ctrl_t [mcu_ctrl_pkg::NUM_PWR_DOMAINS-1:0] pwr_ctrl_o
);

  logic [mcu_ctrl_pkg::NUM_PWR_DOMAINS-1:0] dom_idle;
  logic [mcu_ctrl_pkg::NUM_PWR_DOMAINS-1:0] dom_start;
  logic                                     cpu_off_blocked;
  logic                                     cmd_accept;

  // the cpu can only be switched off once the core sleeps
  assign cpu_off_blocked = (cmd_i.dom == mcu_ctrl_pkg::PWR_DOM_CPU) &&
                           !cmd_i.power_on && !core_sleep_i;

  assign cmd_ready_o = dom_idle[cmd_i.dom] && !cpu_off_blocked;
  assign cmd_accept  = cmd_valid_i && cmd_ready_o;

  for (genvar i = 0; i < mcu_ctrl_pkg::NUM_PWR_DOMAINS; i++) begin : g_dom
    assign dom_start[i] = cmd_accept &&
                          (cmd_i.dom == mcu_ctrl_pkg::pwr_dom_idx_t'(i));

    power_domain_fsm u_dom_fsm (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .start_i    (dom_start[i]),
      .power_on_i (cmd_i.power_on),
      .pwr_ack_ni (pwr_ack_ni[i]),
      .pwr_ctrl_o (pwr_ctrl_o[i]),
      .idle_o     (dom_idle[i])
    );
  end

endmodule

// File: source/fast_irq_ctrl.sv
/*
 * Fast interrupt controller
 * latches fast interrupt lines as pending until cleared
 */
`timescale 1ns/1ps

module fast_irq_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  mcu_ctrl_pkg::fast_irq_t fast_src_i,
  input  logic                    clr_valid_i,
  input  mcu_ctrl_pkg::fast_irq_t clr_mask_i,
  output mcu_ctrl_pkg::fast_irq_t irq_fast_o
);

  mcu_ctrl_pkg::fast_irq_t pending_q;
  mcu_ctrl_pkg::fast_irq_t pending_d;
  mcu_ctrl_pkg::fast_irq_t clr_bits;

  // clear mask only counts on a valid request
  assign clr_bits = clr_valid_i ? clr_mask_i : '0;

  // a source high on the clear edge keeps its bit set
  assign pending_d = fast_src_i | (pending_q & ~clr_bits);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  assign irq_fast_o = pending_q;

endmodule

// File: source/mcu_ctrl_top.sv
/*
 * MCU always-on control top level
 * power sequencing, fast interrupts, core interrupt vector and reset
 */
`timescale 1ns/1ps

module mcu_ctrl_top (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  input  logic                                                   pwr_cmd_valid_i,
  input  mcu_ctrl_pkg::pwr_cmd_t                                 pwr_cmd_i,
  input  mcu_ctrl_pkg::pwr_ack_n_t                               pwr_ack_ni,
  input  logic                                                   core_sleep_i,
  input  logic                                                   debug_ndmreset_ni,
  input  logic                                                   irq_software_i,
  input  logic                                                   irq_timer_i,
  input  logic                                                   irq_external_i,
  input  mcu_ctrl_pkg::fast_irq_t                                fast_irq_i,
  input  logic                                                   clr_valid_i,
  input  mcu_ctrl_pkg::fast_irq_t                                clr_mask_i,
  output logic                                                   pwr_cmd_ready_o,
  output mcu_ctrl_pkg::pwr_ctrl_t [mcu_ctrl_pkg::NUM_PWR_DOMAINS-1:0] pwr_ctrl_o,
  output logic                                                   core_rst_no,
  output mcu_ctrl_pkg::irq_vec_t                                 irq_o
);

  mcu_ctrl_pkg::pwr_ctrl_t [mcu_ctrl_pkg::NUM_PWR_DOMAINS-1:0] pwr_ctrl;
  mcu_ctrl_pkg::fast_irq_t                                     fast_src;
  mcu_ctrl_pkg::fast_irq_t                                     irq_fast;
  mcu_ctrl_pkg::irq_vec_t                                      irq_vec;

  // fast lines come straight from the pins here
  assign fast_src = fast_irq_i;

  power_manager u_power_manager (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cmd_valid_i  (pwr_cmd_valid_i),
    .cmd_i        (pwr_cmd_i),
    .core_sleep_i (core_sleep_i),
    .pwr_ack_ni   (pwr_ack_ni),
    .cmd_ready_o  (pwr_cmd_ready_o),
    .pwr_ctrl_o   (pwr_ctrl)
  );

  fast_irq_ctrl u_fast_irq_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .fast_src_i  (fast_src),
    .clr_valid_i (clr_valid_i),
    .clr_mask_i  (clr_mask_i),
    .irq_fast_o  (irq_fast)
  );

  // core interrupt vector, unused positions stay zero
  always_comb begin
    irq_vec                              = '0;
    irq_vec[mcu_ctrl_pkg::IRQ_SW_BIT]    = irq_software_i;
    irq_vec[mcu_ctrl_pkg::IRQ_TIMER_BIT] = irq_timer_i;
    irq_vec[mcu_ctrl_pkg::IRQ_EXT_BIT]   = irq_external_i;
    irq_vec[mcu_ctrl_pkg::IRQ_FAST_LSB +: mcu_ctrl_pkg::NUM_FAST_IRQ] = irq_fast;
  end

  assign irq_o      = irq_vec;
  assign pwr_ctrl_o = pwr_ctrl;

  // core held in reset by its domain or by the debug module
  assign core_rst_no = pwr_ctrl[mcu_ctrl_pkg::PWR_DOM_CPU].rst_n && debug_ndmreset_ni;

endmodule

// File: tb/tb_mcu_ctrl_checks.svh
/*
 * Testbench compare tasks and random generator
 * typed checks for power control, interrupt vector and single bits
 */
`ifndef TB_MCU_CTRL_CHECKS_SVH
`define TB_MCU_CTRL_CHECKS_SVH

  task automatic check_pwr_ctrl(input mcu_ctrl_pkg::pwr_ctrl_t actual,
                                input mcu_ctrl_pkg::pwr_ctrl_t expected,
                                input string name);
    if (actual !== expected) begin
      stop_on_failure($sformatf("Error at %0t ns: %s is %b, expected %b",
                                $time, name, actual, expected));
    end
  endtask

  task automatic check_irq(input mcu_ctrl_pkg::irq_vec_t actual,
                           input mcu_ctrl_pkg::irq_vec_t expected,
                           input string name);
    if (actual !== expected) begin
      stop_on_failure($sformatf("Error at %0t ns: %s is %h, expected %h",
                                $time, name, actual, expected));
    end
  endtask

  task automatic check_bit(input logic actual,
                           input logic expected,
                           input string name);
    if (actual !== expected) begin
      stop_on_failure($sformatf("Error at %0t ns: %s is %b, expected %b",
                                $time, name, actual, expected));
    end
  endtask

  // 32-bit linear congruential step
  function automatic int unsigned lcg_next(input int unsigned state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

`endif

// File: tb/tb_mcu_ctrl.sv
/*
 * Testbench for the MCU always-on control top level
 * power sequences, cpu sleep rule, fast interrupts and random commands
 */
`timescale 1ns/1ps

module tb_mcu_ctrl;

  localparam int unsigned CYCLE_LIMIT = 4000;

  logic                     clk;
  logic                     rst_n;
  logic                     pwr_cmd_valid;
  mcu_ctrl_pkg::pwr_cmd_t   pwr_cmd;
  mcu_ctrl_pkg::pwr_ack_n_t pwr_ack_n;
  logic                     core_sleep;
  logic                     debug_ndmreset_n;
  logic                     irq_software;
  logic                     irq_timer;
  logic                     irq_external;
  mcu_ctrl_pkg::fast_irq_t  fast_irq;
  logic                     clr_valid;
  mcu_ctrl_pkg::fast_irq_t  clr_mask;
  logic                     pwr_cmd_ready;
  mcu_ctrl_pkg::pwr_ctrl_t [mcu_ctrl_pkg::NUM_PWR_DOMAINS-1:0] pwr_ctrl;
  logic                     core_rst_n;
  mcu_ctrl_pkg::irq_vec_t   irq;

  int unsigned              cycle_count = 0;
  int unsigned              rand_main;
  int unsigned              rand_ack;
  mcu_ctrl_pkg::fast_irq_t  exp_pending = '0;
  logic                     dom_on [4];

  // print the reason, report failure and end the run
  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  `include "tb_mcu_ctrl_checks.svh"

  mcu_ctrl_top uut (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .pwr_cmd_valid_i   (pwr_cmd_valid),
    .pwr_cmd_i         (pwr_cmd),
    .pwr_ack_ni        (pwr_ack_n),
    .core_sleep_i      (core_sleep),
    .debug_ndmreset_ni (debug_ndmreset_n),
    .irq_software_i    (irq_software),
    .irq_timer_i       (irq_timer),
    .irq_external_i    (irq_external),
    .fast_irq_i        (fast_irq),
    .clr_valid_i       (clr_valid),
    .clr_mask_i        (clr_mask),
    .pwr_cmd_ready_o   (pwr_cmd_ready),
    .pwr_ctrl_o        (pwr_ctrl),
    .core_rst_no       (core_rst_n),
    .irq_o             (irq)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // each gating bit is low over its own span of the sequence
  function automatic mcu_ctrl_pkg::pwr_ctrl_t expected_ctrl(input mcu_ctrl_pkg::pwr_state_e st);
    mcu_ctrl_pkg::pwr_ctrl_t c;
    c.isogate_en_n = !(st inside {mcu_ctrl_pkg::PWR_ISO, mcu_ctrl_pkg::PWR_RST,
                                  mcu_ctrl_pkg::PWR_GATE, mcu_ctrl_pkg::PWR_SW_OFF,
                                  mcu_ctrl_pkg::PWR_OFF, mcu_ctrl_pkg::PWR_SW_ON,
                                  mcu_ctrl_pkg::PWR_UNGATE, mcu_ctrl_pkg::PWR_UNRST});
    c.rst_n        = !(st inside {mcu_ctrl_pkg::PWR_RST, mcu_ctrl_pkg::PWR_GATE,
                                  mcu_ctrl_pkg::PWR_SW_OFF, mcu_ctrl_pkg::PWR_OFF,
                                  mcu_ctrl_pkg::PWR_SW_ON, mcu_ctrl_pkg::PWR_UNGATE});
    c.clkgate_en_n = !(st inside {mcu_ctrl_pkg::PWR_GATE, mcu_ctrl_pkg::PWR_SW_OFF,
                                  mcu_ctrl_pkg::PWR_OFF, mcu_ctrl_pkg::PWR_SW_ON});
    c.pwrgate_en_n = !(st inside {mcu_ctrl_pkg::PWR_SW_OFF, mcu_ctrl_pkg::PWR_OFF});
    return c;
  endfunction

  function automatic mcu_ctrl_pkg::irq_vec_t expected_irq(input mcu_ctrl_pkg::fast_irq_t pend,
                                                           input logic sw,
                                                           input logic timer,
                                                           input logic ext);
    mcu_ctrl_pkg::irq_vec_t v;
    v        = '0;
    v[3]     = sw;
    v[7]     = timer;
    v[11]    = ext;
    v[31:16] = pend;
    return v;
  endfunction

  function automatic int unsigned rand_word();
    rand_main = lcg_next(rand_main);
    return rand_main;
  endfunction

  // compares irq_o with the pending model on every rising edge
  always @(posedge clk) begin
    if (rst_n) begin
      check_irq(irq, expected_irq(exp_pending, irq_software, irq_timer, irq_external), "irq_o");
      // a source wins over a clear on the same edge
      for (int b = 0; b < mcu_ctrl_pkg::NUM_FAST_IRQ; b++) begin
        if (fast_irq[b]) begin
          exp_pending[b] = 1'b1;
        end else if (clr_valid && clr_mask[b]) begin
          exp_pending[b] = 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      stop_on_failure($sformatf("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

  // acknowledge follows pwrgate_en_n after 1 to 8 cycles
  initial begin
    int unsigned cnt [4];
    rand_ack  = 94946;
    pwr_ack_n = '1;
    for (int i = 0; i < 4; i++) begin
      cnt[i] = 0;
    end
    forever begin
      @(negedge clk);
      for (int i = 0; i < 4; i++) begin
        if (pwr_ack_n[i] != pwr_ctrl[i].pwrgate_en_n) begin
          if (cnt[i] == 0) begin
            rand_ack = lcg_next(rand_ack);
            cnt[i]   = 32'd1 + ((rand_ack >> 16) % 32'd8);
          end else begin
            cnt[i] = cnt[i] - 1;
            if (cnt[i] == 0) begin
              pwr_ack_n[i] = pwr_ctrl[i].pwrgate_en_n;
            end
          end
        end else begin
          cnt[i] = 0;
        end
      end
    end
  end

  // returns on the falling edge after acceptance
  task automatic send_cmd(input mcu_ctrl_pkg::pwr_dom_idx_t dom, input logic on);
    pwr_cmd.dom      = dom;
    pwr_cmd.power_on = on;
    pwr_cmd_valid    = 1'b1;
    do begin
      @(posedge clk);
    end while (!pwr_cmd_ready);
    @(negedge clk);
    pwr_cmd_valid = 1'b0;
  endtask

  task automatic run_off_check(input mcu_ctrl_pkg::pwr_dom_idx_t dom);
    string name;
    name = $sformatf("pwr_ctrl_o[%0d]", dom);
    check_pwr_ctrl(pwr_ctrl[dom], expected_ctrl(mcu_ctrl_pkg::PWR_ISO), name);
    @(negedge clk);
    check_pwr_ctrl(pwr_ctrl[dom], expected_ctrl(mcu_ctrl_pkg::PWR_RST), name);
    @(negedge clk);
    check_pwr_ctrl(pwr_ctrl[dom], expected_ctrl(mcu_ctrl_pkg::PWR_GATE), name);
    @(negedge clk);
    while (!pwr_cmd_ready) begin
      check_pwr_ctrl(pwr_ctrl[dom], expected_ctrl(mcu_ctrl_pkg::PWR_SW_OFF), name);
      @(negedge clk);
    end
    check_bit(pwr_ack_n[dom], 1'b0, "pwr_ack_ni");
    check_pwr_ctrl(pwr_ctrl[dom], expected_ctrl(mcu_ctrl_pkg::PWR_OFF), name);
    dom_on[dom] = 1'b0;
  endtask

  task automatic run_on_check(input mcu_ctrl_pkg::pwr_dom_idx_t dom);
    string name;
    name = $sformatf("pwr_ctrl_o[%0d]", dom);
    check_pwr_ctrl(pwr_ctrl[dom], expected_ctrl(mcu_ctrl_pkg::PWR_SW_ON), name);
    while (pwr_ctrl[dom] == expected_ctrl(mcu_ctrl_pkg::PWR_SW_ON)) begin
      @(negedge clk);
    end
    check_bit(pwr_ack_n[dom], 1'b1, "pwr_ack_ni");
    check_pwr_ctrl(pwr_ctrl[dom], expected_ctrl(mcu_ctrl_pkg::PWR_UNGATE), name);
    @(negedge clk);
    check_pwr_ctrl(pwr_ctrl[dom], expected_ctrl(mcu_ctrl_pkg::PWR_UNRST), name);
    @(negedge clk);
    check_pwr_ctrl(pwr_ctrl[dom], expected_ctrl(mcu_ctrl_pkg::PWR_UNISO), name);
    check_bit(pwr_cmd_ready, 1'b0, "pwr_cmd_ready_o");
    @(negedge clk);
    check_bit(pwr_cmd_ready, 1'b1, "pwr_cmd_ready_o");
    check_pwr_ctrl(pwr_ctrl[dom], expected_ctrl(mcu_ctrl_pkg::PWR_ON), name);
    dom_on[dom] = 1'b1;
  endtask

  initial begin
    int unsigned                  r;
    int unsigned                  r2;
    mcu_ctrl_pkg::pwr_dom_idx_t   dom;
    logic                         on;
    rand_main        = 94946;
    rst_n            = 1'b0;
    pwr_cmd_valid    = 1'b0;
    pwr_cmd          = '0;
    pwr_cmd.power_on = 1'b1;
    core_sleep       = 1'b0;
    debug_ndmreset_n = 1'b1;
    irq_software     = 1'b0;
    irq_timer        = 1'b0;
    irq_external     = 1'b0;
    fast_irq         = '0;
    clr_valid        = 1'b0;
    clr_mask         = '0;
    for (int i = 0; i < 4; i++) begin
      dom_on[i] = 1'b1;
    end
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    // state after reset
    @(negedge clk);
    for (int i = 0; i < 4; i++) begin
      check_pwr_ctrl(pwr_ctrl[i], 4'b1111, $sformatf("pwr_ctrl_o[%0d]", i));
    end
    check_bit(pwr_cmd_ready, 1'b1, "pwr_cmd_ready_o");
    check_irq(irq, '0, "irq_o");
    check_bit(core_rst_n, 1'b1, "core_rst_no");
    debug_ndmreset_n = 1'b0;
    @(posedge clk);
    check_bit(core_rst_n, 1'b0, "core_rst_no");
    @(negedge clk);
    debug_ndmreset_n = 1'b1;
    @(posedge clk);
    check_bit(core_rst_n, 1'b1, "core_rst_no");
    @(negedge clk);

    // off then on for one random domain
    core_sleep = 1'b1;
    r   = rand_word();
    dom = r[25:24];
    send_cmd(dom, 1'b0);
    run_off_check(dom);
    send_cmd(dom, 1'b1);
    run_on_check(dom);

    // cpu off waits for core sleep
    core_sleep       = 1'b0;
    pwr_cmd.dom      = mcu_ctrl_pkg::PWR_DOM_CPU;
    pwr_cmd.power_on = 1'b0;
    pwr_cmd_valid    = 1'b1;
    repeat (5) begin
      @(posedge clk);
      check_bit(pwr_cmd_ready, 1'b0, "pwr_cmd_ready_o");
    end
    @(negedge clk);
    check_pwr_ctrl(pwr_ctrl[0], expected_ctrl(mcu_ctrl_pkg::PWR_ON), "pwr_ctrl_o[0]");
    core_sleep = 1'b1;
    send_cmd(mcu_ctrl_pkg::PWR_DOM_CPU, 1'b0);
    run_off_check(mcu_ctrl_pkg::PWR_DOM_CPU);
    check_bit(core_rst_n, 1'b0, "core_rst_no");
    send_cmd(mcu_ctrl_pkg::PWR_DOM_CPU, 1'b1);
    run_on_check(mcu_ctrl_pkg::PWR_DOM_CPU);
    check_bit(core_rst_n, 1'b1, "core_rst_no");

    // random interrupt traffic for the compare process
    repeat (200) begin
      r            = rand_word();
      r2           = rand_word();
      fast_irq     = r[31:16] & r2[31:16];
      irq_software = r[13];
      irq_timer    = r[14];
      irq_external = r[15];
      r            = rand_word();
      clr_valid    = r[30];
      clr_mask     = r[29:14];
      @(negedge clk);
    end
    fast_irq     = '0;
    irq_software = 1'b0;
    irq_timer    = 1'b0;
    irq_external = 1'b0;
    clr_valid    = 1'b1;
    clr_mask     = '1;
    @(negedge clk);
    clr_valid = 1'b0;

    // random commands against the tracked domain states
    repeat (200) begin
      r   = rand_word();
      dom = r[25:24];
      on  = r[28];
      send_cmd(dom, on);
      dom_on[dom] = on;
      while (!pwr_cmd_ready) begin
        @(negedge clk);
      end
      for (int i = 0; i < 4; i++) begin
        check_pwr_ctrl(pwr_ctrl[i],
                       expected_ctrl(dom_on[i] ? mcu_ctrl_pkg::PWR_ON : mcu_ctrl_pkg::PWR_OFF),
                       $sformatf("pwr_ctrl_o[%0d]", i));
      end
      check_bit(core_rst_n, dom_on[0], "core_rst_no");
    end

    $display("All checks passed");
    $finish;
  end

endmodule

// File: build.f
+incdir+tb
source/mcu_ctrl_pkg.sv
source/power_domain_fsm.sv
source/power_manager.sv
source/fast_irq_ctrl.sv
source/mcu_ctrl_top.sv
tb/tb_mcu_ctrl.sv

// File: Makefile
# Verilator simulation of the MCU always-on control testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -f build.f --top-module tb_mcu_ctrl -o sim_tb_mcu_ctrl
	./obj_dir/sim_tb_mcu_ctrl | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
